// File: executeControl.sv
//////////////////////////////////////////////////////////////////////
// Execute-stage control register and branch resolution. Loads the
// decode bundle every edge, zeroed by reset or flushE. pcSrcE is
// combinational from the register and the ALU zero flag.
//////////////////////////////////////////////////////////////////////

module executeControl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      flushE_i,
    input  riscvCtrlPkg::decodeCtrl_t decodeCtrlD_i,
    input  logic                      zeroE_i,
    output logic [2:0]                aluControlE_o,
    output logic                      aluSrcE_o,
    output logic [1:0]                resultSrcE_o,
    output logic                      pcSrcE_o,
    output riscvCtrlPkg::memCtrl_t    memCtrlE_o
);
    import riscvCtrlPkg::*;

    decodeCtrl_t decodeCtrlE;
    logic        branchTaken;

    // Flush turns the slot into a bubble
    always_ff @(posedge clk) begin
        if (reset || flushE_i) begin
            decodeCtrlE <= '0;
        end else begin
            decodeCtrlE <= decodeCtrlD_i;
        end
    end

    // ALU side
    assign aluControlE_o = decodeCtrlE.aluControl;
    assign aluSrcE_o     = decodeCtrlE.aluSrc;

    // Hazard unit watches this for loads
    assign resultSrcE_o = decodeCtrlE.resultSrc;

    // beq takes on zero, bne on nonzero
    assign branchTaken = decodeCtrlE.branch & (zeroE_i ^ decodeCtrlE.branchNe);
    assign pcSrcE_o    = branchTaken | decodeCtrlE.jump;

    // What the later stages still need
    assign memCtrlE_o.regWrite  = decodeCtrlE.regWrite;
    assign memCtrlE_o.memWrite  = decodeCtrlE.memWrite;
    assign memCtrlE_o.resultSrc = decodeCtrlE.resultSrc;

    // Decoder never marks one instruction as both branch and jump
    branchJumpExclusive: assert property (
        @(posedge clk) disable iff (reset)
        !(decodeCtrlE.branch && decodeCtrlE.jump)
    ) else $error("branch and jump both set in execute register");

    // A bne needs branch set as well
    branchNeOnlyOnBranch: assert property (
        @(posedge clk) disable iff (reset)
        decodeCtrlE.branchNe |-> decodeCtrlE.branch
    ) else $error("branchNe set without branch in execute register");

endmodule

// File: hazardUnit.sv
//////////////////////////////////////////////////////////////////////
// Hazard unit. Combinational forwarding selects for both execute
// operands, load-use stall toward fetch and decode, and the flushes
// for taken branches, jumps and the stall bubble.
//////////////////////////////////////////////////////////////////////

module hazardUnit (
    input  riscvCtrlPkg::regAddr_t rs1D_i,
    input  riscvCtrlPkg::regAddr_t rs2D_i,
    input  riscvCtrlPkg::regAddr_t rs1E_i,
    input  riscvCtrlPkg::regAddr_t rs2E_i,
    input  riscvCtrlPkg::regAddr_t rdE_i,
    input  riscvCtrlPkg::regAddr_t rdM_i,
    input  riscvCtrlPkg::regAddr_t rdW_i,
    input  logic [1:0]             resultSrcE_i,
    input  logic                   pcSrcE_i,
    input  logic                   regWriteM_i,
    input  logic                   regWriteW_i,
    output logic [1:0]             forwardAE_o,
    output logic [1:0]             forwardBE_o,
    output logic                   stallF_o,
    output logic                   stallD_o,
    output logic                   flushD_o,
    output logic                   flushE_o
);
    import riscvCtrlPkg::*;

    logic lwStall;
    logic loadInE;

    // Memory stage wins over writeback; x0 never forwards
    function automatic logic [1:0] fwdSelect(input regAddr_t rsE);
        logic [1:0] sel;
        sel = fwdNone;
        if ((rsE != '0) && regWriteM_i && (rsE == rdM_i)) begin
            sel = fwdMem;
        end else if ((rsE != '0) && regWriteW_i && (rsE == rdW_i)) begin
            sel = fwdWb;
        end
        return sel;
    endfunction

    assign forwardAE_o = fwdSelect(rs1E_i);
    assign forwardBE_o = fwdSelect(rs2E_i);

    // Load in execute, data not ready until after memory
    assign loadInE = (resultSrcE_i == resMem);

    always_comb begin
        lwStall  = loadInE && (rdE_i != '0) && ((rs1D_i == rdE_i) || (rs2D_i == rdE_i));
        stallF_o = lwStall;
        stallD_o = lwStall;
        // Redirect kills decode; stall or redirect kills execute
        flushD_o = pcSrcE_i;
        flushE_o = lwStall | pcSrcE_i;
        // Loaded register not taken from memory while stalling on it
        if (lwStall) begin
            assert (!((forwardAE_o == fwdMem) && (rs1E_i == rdE_i)) &&
                    !((forwardBE_o == fwdMem) && (rs2E_i == rdE_i)))
                else $error("load-use stall while loaded register forwards from memory");
        end
    end

endmodule

// File: instrDecoder.sv
//////////////////////////////////////////////////////////////////////
// Decode-stage control. Main decoder on the opcode plus ALU decoder
// on class and funct3; the result feeds the execute register.
// Unsupported encodings come out as an all-zero bubble.
//////////////////////////////////////////////////////////////////////

module instrDecoder (
    input  logic [6:0]                op_i,
    input  logic [2:0]                funct3_i,
    input  logic                      funct7b5_i,
    output riscvCtrlPkg::decodeCtrl_t decodeCtrl_o
);
    import riscvCtrlPkg::*;

    decodeCtrl_t mainCtrl;
    logic [1:0]  aluOp;
    logic        opKnown;
    logic [2:0]  aluControl;
    logic        branchNe;
    logic        funct3Known;
    logic        rtypeSub;

    // Only R-type uses funct7[5] for subtract; addi keeps imm bit 10
    assign rtypeSub = funct7b5_i & op_i[5];

    // Main decoder
    always_comb begin
        mainCtrl = '0;
        aluOp    = aluOpMem;
        opKnown  = 1'b1;
        case (op_i)
            opLoad: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.immSrc    = immI;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.resultSrc = resMem;
            end
            opStore: begin
                mainCtrl.immSrc   = immS;
                mainCtrl.aluSrc   = 1'b1;
                mainCtrl.memWrite = 1'b1;
            end
            opRtype: begin
                mainCtrl.regWrite = 1'b1;
                aluOp             = aluOpFunct;
            end
            opBranch: begin
                mainCtrl.immSrc = immB;
                mainCtrl.branch = 1'b1;
                aluOp           = aluOpBranch;
            end
            opItypeAlu: begin
                mainCtrl.regWrite = 1'b1;
                mainCtrl.immSrc   = immI;
                mainCtrl.aluSrc   = 1'b1;
                aluOp             = aluOpFunct;
            end
            opJal: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.immSrc    = immJ;
                mainCtrl.resultSrc = resPcPlus4;
                mainCtrl.jump      = 1'b1;
            end
            opJalr: begin
                // Target is rs1 + imm through the ALU
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.immSrc    = immI;
                mainCtrl.aluSrc    = 1'b1;
                mainCtrl.resultSrc = resPcPlus4;
                mainCtrl.jump      = 1'b1;
            end
            opLui: begin
                mainCtrl.regWrite  = 1'b1;
                mainCtrl.immSrc    = immU;
                mainCtrl.resultSrc = resImm;
            end
            default: opKnown = 1'b0;
        endcase
    end

    // ALU decoder, also picks beq/bne
    always_comb begin
        aluControl  = aluAdd;
        branchNe    = 1'b0;
        funct3Known = 1'b1;
        case (aluOp)
            aluOpMem: aluControl = aluAdd;
            aluOpBranch: begin
                // Compare by subtract, zero flag decides
                aluControl = aluSub;
                case (funct3_i)
                    f3Beq:   branchNe    = 1'b0;
                    f3Bne:   branchNe    = 1'b1;
                    default: funct3Known = 1'b0;
                endcase
            end
            aluOpFunct: begin
                case (funct3_i)
                    f3AddSub: aluControl  = rtypeSub ? aluSub : aluAdd;
                    f3Slt:    aluControl  = aluSlt;
                    f3Or:     aluControl  = aluOr;
                    f3And:    aluControl  = aluAnd;
                    default:  funct3Known = 1'b0;
                endcase
            end
            default: funct3Known = 1'b0;
        endcase
    end

    // Merge; anything unknown becomes a bubble
    always_comb begin
        decodeCtrl_o = '0;
        if (opKnown && funct3Known) begin
            decodeCtrl_o            = mainCtrl;
            decodeCtrl_o.branchNe   = branchNe;
            decodeCtrl_o.aluControl = aluControl;
        end
    end

endmodule

// File: pipelineController.f
+incdir+.
riscvCtrlPkg.sv
instrDecoder.sv
executeControl.sv
resultControl.sv
hazardUnit.sv
pipelineController.sv
pipelineController_tb.sv

// File: pipelineController.sv
//////////////////////////////////////////////////////////////////////
// Top of the pipeline control half. Wires the decoder, execute,
// memory/writeback and hazard blocks; the datapath sits outside
// and drives opcode fields, zero flag and register numbers.
//////////////////////////////////////////////////////////////////////

module pipelineController (
    input  logic                   clk,
    input  logic                   reset,
    input  logic [6:0]             op_i,
    input  logic [2:0]             funct3_i,
    input  logic                   funct7b5_i,
    input  logic                   zeroE_i,
    input  riscvCtrlPkg::regAddr_t rs1D_i,
    input  riscvCtrlPkg::regAddr_t rs2D_i,
    input  riscvCtrlPkg::regAddr_t rs1E_i,
    input  riscvCtrlPkg::regAddr_t rs2E_i,
    input  riscvCtrlPkg::regAddr_t rdE_i,
    input  riscvCtrlPkg::regAddr_t rdM_i,
    input  riscvCtrlPkg::regAddr_t rdW_i,
    output logic                   stallF_o,
    output logic                   stallD_o,
    output logic                   flushD_o,
    output logic [2:0]             immSrcD_o,
    output logic                   pcSrcE_o,
    output logic [2:0]             aluControlE_o,
    output logic                   aluSrcE_o,
    output logic [1:0]             forwardAE_o,
    output logic [1:0]             forwardBE_o,
    output logic                   memWriteM_o,
    output logic                   regWriteW_o,
    output logic [1:0]             resultSrcM_o,
    output logic [1:0]             resultSrcW_o
);
    import riscvCtrlPkg::*;

    decodeCtrl_t decodeCtrlD;
    memCtrl_t    memCtrlE;
    logic [1:0]  resultSrcE;
    logic        regWriteM;
    logic        flushE;

    // Decode
    instrDecoder uDecoder (
        .op_i         (op_i),
        .funct3_i     (funct3_i),
        .funct7b5_i   (funct7b5_i),
        .decodeCtrl_o (decodeCtrlD)
    );

    // Immediate format goes straight to the datapath
    assign immSrcD_o = decodeCtrlD.immSrc;

    // Execute
    executeControl uExecute (
        .clk           (clk),
        .reset         (reset),
        .flushE_i      (flushE),
        .decodeCtrlD_i (decodeCtrlD),
        .zeroE_i       (zeroE_i),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .resultSrcE_o  (resultSrcE),
        .pcSrcE_o      (pcSrcE_o),
        .memCtrlE_o    (memCtrlE)
    );

    // Memory and writeback
    resultControl uResult (
        .clk          (clk),
        .reset        (reset),
        .memCtrlE_i   (memCtrlE),
        .memWriteM_o  (memWriteM_o),
        .resultSrcM_o (resultSrcM_o),
        .regWriteM_o  (regWriteM),
        .regWriteW_o  (regWriteW_o),
        .resultSrcW_o (resultSrcW_o)
    );

    // Forwarding, stall, flush
    hazardUnit uHazard (
        .rs1D_i       (rs1D_i),
        .rs2D_i       (rs2D_i),
        .rs1E_i       (rs1E_i),
        .rs2E_i       (rs2E_i),
        .rdE_i        (rdE_i),
        .rdM_i        (rdM_i),
        .rdW_i        (rdW_i),
        .resultSrcE_i (resultSrcE),
        .pcSrcE_i     (pcSrcE_o),
        .regWriteM_i  (regWriteM),
        .regWriteW_i  (regWriteW_o),
        .forwardAE_o  (forwardAE_o),
        .forwardBE_o  (forwardBE_o),
        .stallF_o     (stallF_o),
        .stallD_o     (stallD_o),
        .flushD_o     (flushD_o),
        .flushE_o     (flushE)
    );

endmodule

// File: tbVectors.svh
//////////////////////////////////////////////////////////////////////
// Stimulus and expected values for the pipeline controller
// testbench. One row per decode slot, included inside the
// testbench module and loaded once before the vector loop.
//////////////////////////////////////////////////////////////////////

`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

localparam int numRows = 30;

// Columns: op, funct3, funct7b5, zero flag while this slot is in execute, rs1D, rs2D,
// rdE this cycle, expected immSrc, aluControl, {stall, aluSrc, pcSrc, memWrite,
// regWrite}, resultSrc in writeback
task automatic loadVectors;
    // ALU ops, checked one cycle after decode
    addRow(opRtype, f3AddSub, 1'b0, 1'b0, 5'd1, 5'd2, 5'd0, immI, aluAdd, 5'b00001, resAlu);
    addRow(opRtype, f3AddSub, 1'b1, 1'b0, 5'd3, 5'd4, 5'd0, immI, aluSub, 5'b00001, resAlu);
    addRow(opRtype, f3Slt, 1'b0, 1'b0, 5'd5, 5'd6, 5'd0, immI, aluSlt, 5'b00001, resAlu);
    addRow(opItypeAlu, f3Or, 1'b0, 1'b0, 5'd7, 5'd0, 5'd0, immI, aluOr, 5'b01001, resAlu);
    addRow(opRtype, f3And, 1'b0, 1'b0, 5'd8, 5'd9, 5'd0, immI, aluAnd, 5'b00001, resAlu);
    // addi with imm bit 10 set stays an add
    addRow(opItypeAlu, f3AddSub, 1'b1, 1'b0, 5'd1, 5'd0, 5'd0, immI, aluAdd, 5'b01001, resAlu);
    // Store, then lui and load for writeback
    addRow(opStore, 3'b010, 1'b0, 1'b0, 5'd2, 5'd3, 5'd0, immS, aluAdd, 5'b01010, resAlu);
    addRow(opLui, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immU, aluAdd, 5'b00001, resImm);
    addRow(opLoad, 3'b010, 1'b0, 1'b0, 5'd3, 5'd0, 5'd0, immI, aluAdd, 5'b01001, resMem);
    // Load-use on rs1, bubble then the same add again
    addRow(opRtype, f3AddSub, 1'b0, 1'b0, 5'd5, 5'd6, 5'd5, immI, aluAdd, 5'b10000, resAlu);
    addRow(opRtype, f3AddSub, 1'b0, 1'b0, 5'd5, 5'd6, 5'd0, immI, aluAdd, 5'b00001, resAlu);
    // Load to x0 never stalls
    addRow(opLoad, 3'b010, 1'b0, 1'b0, 5'd2, 5'd0, 5'd7, immI, aluAdd, 5'b01001, resMem);
    addRow(opRtype, f3Or, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immI, aluOr, 5'b00001, resAlu);
    // Load-use on rs2
    addRow(opLoad, 3'b010, 1'b0, 1'b0, 5'd4, 5'd0, 5'd4, immI, aluAdd, 5'b01001, resMem);
    addRow(opRtype, f3And, 1'b0, 1'b0, 5'd1, 5'd9, 5'd9, immI, aluAdd, 5'b10000, resAlu);
    addRow(opRtype, f3And, 1'b0, 1'b0, 5'd1, 5'd9, 5'd0, immI, aluAnd, 5'b00001, resAlu);
    // Branches, a taken one kills the next slot
    addRow(opBranch, f3Beq, 1'b0, 1'b1, 5'd1, 5'd2, 5'd10, immB, aluSub, 5'b00100, resAlu);
    addRow(opRtype, f3AddSub, 1'b0, 1'b0, 5'd3, 5'd4, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    addRow(opBranch, f3Beq, 1'b0, 1'b0, 5'd1, 5'd2, 5'd0, immB, aluSub, 5'b00000, resAlu);
    addRow(opBranch, f3Bne, 1'b0, 1'b0, 5'd1, 5'd2, 5'd0, immB, aluSub, 5'b00100, resAlu);
    addRow(opItypeAlu, f3AddSub, 1'b0, 1'b0, 5'd1, 5'd0, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    addRow(opBranch, f3Bne, 1'b0, 1'b1, 5'd1, 5'd2, 5'd0, immB, aluSub, 5'b00000, resAlu);
    // Jumps always redirect
    addRow(opJal, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immJ, aluAdd, 5'b00101, resPcPlus4);
    addRow(opRtype, f3AddSub, 1'b1, 1'b0, 5'd3, 5'd4, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    addRow(opJalr, 3'b000, 1'b0, 1'b1, 5'd1, 5'd0, 5'd0, immI, aluAdd, 5'b01101, resPcPlus4);
    addRow(opLui, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immU, aluAdd, 5'b00000, resAlu);
    // Unsupported funct3 decodes to a bubble
    addRow(opRtype, 3'b001, 1'b0, 1'b0, 5'd1, 5'd2, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    // Drain slots
    addRow(7'b0000000, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    addRow(7'b0000000, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immI, aluAdd, 5'b00000, resAlu);
    addRow(7'b0000000, 3'b000, 1'b0, 1'b0, 5'd0, 5'd0, 5'd0, immI, aluAdd, 5'b00000, resAlu);
endtask

`endif

// File: pipelineController_tb.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the pipeline controller. Runs the decode table
// from tbVectors.svh through all stages, then a random phase that
// checks forwarding against a reference of the hazard rules.
//////////////////////////////////////////////////////////////////////

module pipelineController_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import riscvCtrlPkg::*;

    localparam int clkPeriod   = 100;
    localparam int driveDelay  = 10;
    localparam int sampleDelay = 50;
    localparam int numRandom   = 200;

    logic       clk;
    logic       reset;
    logic [6:0] op_i;
    logic [2:0] funct3_i;
    logic       funct7b5_i;
    logic       zeroE_i;
    regAddr_t   rs1D_i;
    regAddr_t   rs2D_i;
    regAddr_t   rs1E_i;
    regAddr_t   rs2E_i;
    regAddr_t   rdE_i;
    regAddr_t   rdM_i;
    regAddr_t   rdW_i;
    logic       stallF_o;
    logic       stallD_o;
    logic       flushD_o;
    logic [2:0] immSrcD_o;
    logic       pcSrcE_o;
    logic [2:0] aluControlE_o;
    logic       aluSrcE_o;
    logic [1:0] forwardAE_o;
    logic [1:0] forwardBE_o;
    logic       memWriteM_o;
    logic       regWriteW_o;
    logic [1:0] resultSrcM_o;
    logic [1:0] resultSrcW_o;

    int errorCount;
    int rowCount;

    // One decode slot, expFlags is {stall, aluSrc, pcSrc, memWrite, regWrite}
    typedef struct packed {
        logic [6:0] op;
        logic [2:0] funct3;
        logic       funct7b5;
        logic       zero;
        regAddr_t   rs1D;
        regAddr_t   rs2D;
        regAddr_t   rdE;
        logic [2:0] expImm;
        logic [2:0] expAlu;
        logic [4:0] expFlags;
        logic [1:0] expResW;
    } vectorRow_t;

    `include "tbVectors.svh"

    localparam int watchdogCycles = numRows + numRandom + 20;

    vectorRow_t vectors[numRows];
    // Write enable issued per random cycle
    logic       weHist[numRandom];

    pipelineController DUT (
        .clk           (clk),
        .reset         (reset),
        .op_i          (op_i),
        .funct3_i      (funct3_i),
        .funct7b5_i    (funct7b5_i),
        .zeroE_i       (zeroE_i),
        .rs1D_i        (rs1D_i),
        .rs2D_i        (rs2D_i),
        .rs1E_i        (rs1E_i),
        .rs2E_i        (rs2E_i),
        .rdE_i         (rdE_i),
        .rdM_i         (rdM_i),
        .rdW_i         (rdW_i),
        .stallF_o      (stallF_o),
        .stallD_o      (stallD_o),
        .flushD_o      (flushD_o),
        .immSrcD_o     (immSrcD_o),
        .pcSrcE_o      (pcSrcE_o),
        .aluControlE_o (aluControlE_o),
        .aluSrcE_o     (aluSrcE_o),
        .forwardAE_o   (forwardAE_o),
        .forwardBE_o   (forwardBE_o),
        .memWriteM_o   (memWriteM_o),
        .regWriteW_o   (regWriteW_o),
        .resultSrcM_o  (resultSrcM_o),
        .resultSrcW_o  (resultSrcW_o)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // Ends a stuck run
    initial begin
        #(watchdogCycles * clkPeriod);
        $display("Timeout, run still going after %0d clock cycles", watchdogCycles);
        $display("=== FAIL ===");
        $finish;
    end

    task automatic reportMismatch(
        input string      step,
        input string      name,
        input logic [7:0] got,
        input logic [7:0] expected
    );
        errorCount++;
        $display("mismatch %s at %s: got 0x%0h, expected 0x%0h", name, step, got, expected);
    endtask

    task automatic addRow(
        input logic [6:0] op,
        input logic [2:0] funct3,
        input logic       funct7b5,
        input logic       zero,
        input regAddr_t   rs1D,
        input regAddr_t   rs2D,
        input regAddr_t   rdE,
        input logic [2:0] expImm,
        input logic [2:0] expAlu,
        input logic [4:0] expFlags,
        input logic [1:0] expResW
    );
        if (rowCount >= numRows) begin
            errorCount++;
            $display("Vector table is longer than %0d rows", numRows);
        end else begin
            vectors[rowCount] = '{op, funct3, funct7b5, zero, rs1D, rs2D, rdE,
                                  expImm, expAlu, expFlags, expResW};
            rowCount++;
        end
    endtask

    // Forwarding select by the hazard rules
    function automatic logic [1:0] refForward(
        input regAddr_t rsE,
        input regAddr_t rdM,
        input logic     weM,
        input regAddr_t rdW,
        input logic     weW
    );
        logic [1:0] sel;
        // x0 is hardwired, nothing to forward
        if (rsE == 5'd0) begin
            sel = fwdNone;
        end else if (weM && (rsE == rdM)) begin
            sel = fwdMem;   // newest value wins
        end else if (weW && (rsE == rdW)) begin
            sel = fwdWb;
        end else begin
            sel = fwdNone;
        end
        return sel;
    endfunction

    // All stages cleared, rdM/rdW match but nothing writes
    task automatic checkReset;
        if (pcSrcE_o !== 1'b0) begin
            reportMismatch("reset", "pcSrcE_o", 8'(pcSrcE_o), 8'h0);
        end
        if (flushD_o !== 1'b0) begin
            reportMismatch("reset", "flushD_o", 8'(flushD_o), 8'h0);
        end
        if (memWriteM_o !== 1'b0) begin
            reportMismatch("reset", "memWriteM_o", 8'(memWriteM_o), 8'h0);
        end
        if (regWriteW_o !== 1'b0) begin
            reportMismatch("reset", "regWriteW_o", 8'(regWriteW_o), 8'h0);
        end
        if (forwardAE_o !== fwdNone) begin
            reportMismatch("reset", "forwardAE_o", 8'(forwardAE_o), 8'(fwdNone));
        end
        if (forwardBE_o !== fwdNone) begin
            reportMismatch("reset", "forwardBE_o", 8'(forwardBE_o), 8'(fwdNone));
        end
    endtask

    // Row i decodes in cycle i, executes in i+1, memory i+2, writeback i+3
    task automatic applyVectors;
        vectorRow_t cur;
        vectorRow_t exRow;
        vectorRow_t memRow;
        vectorRow_t wbRow;
        string      step;
        rs1E_i = 5'd0;
        rs2E_i = 5'd0;
        rdM_i  = 5'd0;
        rdW_i  = 5'd0;
        for (int i = 0; i < numRows; i++) begin
            @(posedge clk);
            #driveDelay;
            cur        = vectors[i];
            step       = $sformatf("row %0d", i);
            op_i       = cur.op;
            funct3_i   = cur.funct3;
            funct7b5_i = cur.funct7b5;
            rs1D_i     = cur.rs1D;
            rs2D_i     = cur.rs2D;
            rdE_i      = cur.rdE;
            // Zero flag belongs to the slot now in execute
            zeroE_i    = (i > 0) ? vectors[i - 1].zero : 1'b0;
            #sampleDelay;
            if (immSrcD_o !== cur.expImm) begin
                reportMismatch(step, "immSrcD_o", 8'(immSrcD_o), 8'(cur.expImm));
            end
            if (stallF_o !== cur.expFlags[4]) begin
                reportMismatch(step, "stallF_o", 8'(stallF_o), 8'(cur.expFlags[4]));
            end
            if (stallD_o !== cur.expFlags[4]) begin
                reportMismatch(step, "stallD_o", 8'(stallD_o), 8'(cur.expFlags[4]));
            end
            if (i >= 1) begin
                exRow = vectors[i - 1];
                if (aluControlE_o !== exRow.expAlu) begin
                    reportMismatch(step, "aluControlE_o", 8'(aluControlE_o), 8'(exRow.expAlu));
                end
                if (aluSrcE_o !== exRow.expFlags[3]) begin
                    reportMismatch(step, "aluSrcE_o", 8'(aluSrcE_o), 8'(exRow.expFlags[3]));
                end
                if (pcSrcE_o !== exRow.expFlags[2]) begin
                    reportMismatch(step, "pcSrcE_o", 8'(pcSrcE_o), 8'(exRow.expFlags[2]));
                end
                if (flushD_o !== exRow.expFlags[2]) begin
                    reportMismatch(step, "flushD_o", 8'(flushD_o), 8'(exRow.expFlags[2]));
                end
            end
            if (i >= 2) begin
                memRow = vectors[i - 2];
                if (memWriteM_o !== memRow.expFlags[1]) begin
                    reportMismatch(step, "memWriteM_o", 8'(memWriteM_o), 8'(memRow.expFlags[1]));
                end
                // Result select is already known in memory
                if (resultSrcM_o !== memRow.expResW) begin
                    reportMismatch(step, "resultSrcM_o", 8'(resultSrcM_o), 8'(memRow.expResW));
                end
            end
            if (i >= 3) begin
                wbRow = vectors[i - 3];
                if (regWriteW_o !== wbRow.expFlags[0]) begin
                    reportMismatch(step, "regWriteW_o", 8'(regWriteW_o), 8'(wbRow.expFlags[0]));
                end
                if (resultSrcW_o !== wbRow.expResW) begin
                    reportMismatch(step, "resultSrcW_o", 8'(resultSrcW_o), 8'(wbRow.expResW));
                end
            end
        end
    endtask

    // Add or store per cycle sets regWrite two and three cycles later
    task automatic runRandomForwarding;
        logic       writeEn;
        logic       weM;
        logic       weW;
        logic [1:0] expA;
        logic [1:0] expB;
        string      step;
        funct7b5_i = 1'b0;
        zeroE_i    = 1'b0;
        for (int c = 0; c < numRandom; c++) begin
            @(posedge clk);
            #driveDelay;
            step       = $sformatf("random %0d", c);
            writeEn    = 1'($urandom_range(1, 0));
            weHist[c]  = writeEn;
            op_i       = writeEn ? opRtype : opStore;
            funct3_i   = writeEn ? f3AddSub : 3'b010;
            rs1D_i     = regAddr_t'($urandom_range(31, 0));
            rs2D_i     = regAddr_t'($urandom_range(31, 0));
            rdE_i      = regAddr_t'($urandom_range(31, 0));
            // Narrow range so matches and x0 come up often
            rs1E_i     = regAddr_t'($urandom_range(3, 0));
            rs2E_i     = regAddr_t'($urandom_range(3, 0));
            rdM_i      = regAddr_t'($urandom_range(3, 0));
            rdW_i      = regAddr_t'($urandom_range(3, 0));
            #sampleDelay;
            // Drain rows ahead of this phase never write
            weM  = (c >= 2) ? weHist[c - 2] : 1'b0;
            weW  = (c >= 3) ? weHist[c - 3] : 1'b0;
            expA = refForward(rs1E_i, rdM_i, weM, rdW_i, weW);
            expB = refForward(rs2E_i, rdM_i, weM, rdW_i, weW);
            if (forwardAE_o !== expA) begin
                reportMismatch(step, "forwardAE_o", 8'(forwardAE_o), 8'(expA));
            end
            if (forwardBE_o !== expB) begin
                reportMismatch(step, "forwardBE_o", 8'(forwardBE_o), 8'(expB));
            end
            // No load or redirect in execute here
            if (stallF_o !== 1'b0) begin
                reportMismatch(step, "stallF_o", 8'(stallF_o), 8'h0);
            end
            if (flushD_o !== 1'b0) begin
                reportMismatch(step, "flushD_o", 8'(flushD_o), 8'h0);
            end
        end
    endtask

    initial begin
        void'($urandom(34));
        errorCount = 0;
        rowCount   = 0;
        reset      = 1'b1;
        op_i       = 7'b0000000;
        funct3_i   = 3'b000;
        funct7b5_i = 1'b0;
        zeroE_i    = 1'b0;
        rs1D_i     = 5'd0;
        rs2D_i     = 5'd0;
        rdE_i      = 5'd0;
        // Matching numbers, forwarding must still stay off after reset
        rs1E_i     = 5'd3;
        rs2E_i     = 5'd4;
        rdM_i      = 5'd3;
        rdW_i      = 5'd4;
        loadVectors();
        if (rowCount != numRows) begin
            errorCount++;
            $display("Vector table holds %0d rows instead of %0d", rowCount, numRows);
        end
        repeat (2) @(posedge clk);
        #driveDelay;
        reset = 1'b0;
        #sampleDelay;
        checkReset();
        applyVectors();
        runRandomForwarding();
        $display("Run complete, %0d errors", errorCount);
        if (errorCount == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: resultControl.sv
//////////////////////////////////////////////////////////////////////
// Memory and writeback control registers. Move the leftover
// controls one stage per edge; neither stage is stalled or flushed.
//////////////////////////////////////////////////////////////////////

module resultControl (
    input  logic                   clk,
    input  logic                   reset,
    input  riscvCtrlPkg::memCtrl_t memCtrlE_i,
    output logic                   memWriteM_o,
    output logic [1:0]             resultSrcM_o,
    output logic                   regWriteM_o,
    output logic                   regWriteW_o,
    output logic [1:0]             resultSrcW_o
);
    import riscvCtrlPkg::*;

    memCtrl_t memCtrlM;
    wbCtrl_t  wbCtrlW;

    // Memory stage
    always_ff @(posedge clk) begin
        if (reset) begin
            memCtrlM <= '0;
        end else begin
            memCtrlM <= memCtrlE_i;
        end
    end

    // Writeback stage, memWrite is dropped here
    always_ff @(posedge clk) begin
        if (reset) begin
            wbCtrlW <= '0;
        end else begin
            wbCtrlW.regWrite  <= memCtrlM.regWrite;
            wbCtrlW.resultSrc <= memCtrlM.resultSrc;
        end
    end

    assign memWriteM_o  = memCtrlM.memWrite;
    assign resultSrcM_o = memCtrlM.resultSrc;
    assign regWriteM_o  = memCtrlM.regWrite;
    assign regWriteW_o  = wbCtrlW.regWrite;
    assign resultSrcW_o = wbCtrlW.resultSrc;

    // Stores never write the register file
    storeNoRegWrite: assert property (
        @(posedge clk) disable iff (reset)
        !(memCtrlM.memWrite && memCtrlM.regWrite)
    ) else $error("memWrite and regWrite both set in memory stage");

endmodule

// File: riscvCtrlPkg.sv
//////////////////////////////////////////////////////////////////////
// Shared encodings and control structs for the RV32I pipeline
// controller. Every control block imports this package for opcodes,
// funct3 codes, ALU and result selects and the per-stage bundles.
//////////////////////////////////////////////////////////////////////

package riscvCtrlPkg;

    // Major opcodes of the supported subset
    localparam logic [6:0] opLoad     = 7'b0000011;
    localparam logic [6:0] opStore    = 7'b0100011;
    localparam logic [6:0] opRtype    = 7'b0110011;
    localparam logic [6:0] opBranch   = 7'b1100011;
    localparam logic [6:0] opItypeAlu = 7'b0010011;
    localparam logic [6:0] opJal      = 7'b1101111;
    localparam logic [6:0] opJalr     = 7'b1100111;
    localparam logic [6:0] opLui      = 7'b0110111;

    // funct3 codes, ALU group
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;
    // funct3 codes, branch group
    localparam logic [2:0] f3Beq    = 3'b000;
    localparam logic [2:0] f3Bne    = 3'b001;

    // ALU control, zero is add
    localparam logic [2:0] aluAdd = 3'b000;
    localparam logic [2:0] aluSub = 3'b001;
    localparam logic [2:0] aluAnd = 3'b010;
    localparam logic [2:0] aluOr  = 3'b011;
    localparam logic [2:0] aluSlt = 3'b101;

    // Instruction class from the main decoder
    localparam logic [1:0] aluOpMem    = 2'b00;
    localparam logic [1:0] aluOpBranch = 2'b01;
    localparam logic [1:0] aluOpFunct  = 2'b10;

    // Immediate formats seen by the external immediate generator
    localparam logic [2:0] immI = 3'b000;
    localparam logic [2:0] immS = 3'b001;
    localparam logic [2:0] immB = 3'b010;
    localparam logic [2:0] immJ = 3'b011;
    localparam logic [2:0] immU = 3'b100;

    // Writeback result mux
    localparam logic [1:0] resAlu     = 2'b00;
    localparam logic [1:0] resMem     = 2'b01;
    localparam logic [1:0] resPcPlus4 = 2'b10;
    localparam logic [1:0] resImm     = 2'b11;

    // Operand forwarding mux in execute
    localparam logic [1:0] fwdNone = 2'b00;
    localparam logic [1:0] fwdWb   = 2'b01;
    localparam logic [1:0] fwdMem  = 2'b10;

    typedef logic [4:0] regAddr_t;

    // Everything decode hands to execute, 14 bits
    typedef struct packed {
        logic       regWrite;
        logic [2:0] immSrc;
        logic       aluSrc;
        logic       memWrite;
        logic [1:0] resultSrc;
        logic       branch;
        logic       branchNe;   // bne, inverts zero
        logic       jump;
        logic [2:0] aluControl;
    } decodeCtrl_t;

    // Left after execute
    typedef struct packed {
        logic       regWrite;
        logic       memWrite;
        logic [1:0] resultSrc;
    } memCtrl_t;

    // Left after memory
    typedef struct packed {
        logic       regWrite;
        logic [1:0] resultSrc;
    } wbCtrl_t;

endpackage

// File: runSim.sh
#!/usr/bin/env bash
# Builds the pipeline controller testbench with Verilator and runs it.
# Exits nonzero if the build or the run fails, or the log shows a failure.

cd "$(dirname "$0")" || exit 1

buildDir=obj_dir
simBinary=pipelineSim
logFile=sim.log
failMsg="=== FAIL ==="

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    --top-module pipelineController_tb \
    --Mdir "$buildDir" -o "$simBinary" \
    -f pipelineController.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$buildDir/$simBinary" > "$logFile" 2>&1
simStatus=$?
cat "$logFile"
if [ $simStatus -ne 0 ]; then
    echo "Simulation exited with status $simStatus"
    exit 1
fi

if grep -qF "$failMsg" "$logFile"; then
    echo "Simulation reported a failure, see $logFile"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
